// ==== verilog.f ====
verilog/cacheGeometryPkg.sv
verilog/cacheRequestPkg.sv
verilog/dataBank.sv
verilog/responseStage.sv
verilog/dataArray.sv
dv/clockGen.sv
dv/dataArrayTb.sv

// ==== Bender.yml ====
package:
  name: data_array

sources:
  # packages first, the modules import them
  - verilog/cacheGeometryPkg.sv
  - verilog/cacheRequestPkg.sv
  - verilog/dataBank.sv
  - verilog/responseStage.sv
  - verilog/dataArray.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/dataArrayTb.sv

// ==== dv/dataArrayTb.sv ====
// table-driven testbench for the L1 data array
// a row model per way predicts each response and checks it when it reaches the outputs
`timescale 1ns/1ps

module dataArrayTb
  import cacheGeometryPkg::*;
  import cacheRequestPkg::*;
();

  // one table entry holds both request buses for one cycle
  typedef struct packed {
    dataReadReqT  rd;
    dataWriteReqT wr;
  } stimT;

  // predicted outputs after a given cycle
  // entry -1 stands for the reset state
  typedef struct packed {
    int                 entry;
    wayMaskT            valid;
    rowT [nWays-1:0]    data;
  } expectT;

  logic         clock;
  logic         reset;
  dataReadReqT  readReq;
  dataWriteReqT writeReq;
  rowT          respData [nWays];
  wayMaskT      respWayValid;

  // stimulus table and the names of its entries
  stimT  steps [$];
  string stepNames [$];
  bit    tableReady;

  // reference model of the array and of each way's response register
  rowT refMem [nWays][nRows];
  rowT lastResp [nWays];

  // responses still travelling through the two register stages
  expectT pending [$];

  integer seed;
  int     validErrors;
  int     dataErrors;

  clockGen clockGen_i (
    .clock(clock),
    .reset(reset)
  );

  dataArray dataArray_i (
    .clock       (clock),
    .reset       (reset),
    .readReq     (readReq),
    .writeReq    (writeReq),
    .respData    (respData),
    .respWayValid(respWayValid)
  );

  // append one cycle to the table
  // write data comes from the seeded generator
  task automatic addStep(input string name, input logic rdValid, input wayMaskT rdWay,
                         input addrT rdAddr, input logic wrValid, input wayMaskT wrWay,
                         input addrT wrAddr, input wordMaskT wrMask);
    stimT s;
    s = '0;
    s.rd.valid = rdValid;
    s.rd.wayEn = rdWay;
    s.rd.addr = rdAddr;
    s.wr.valid = wrValid;
    s.wr.wayEn = wrWay;
    s.wr.addr = wrAddr;
    s.wr.wordMask = wrMask;
    s.wr.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
    steps.push_back(s);
    stepNames.push_back(name);
  endtask

  function automatic string testName(input int entry);
    if (entry < 0) begin
      return "reset";
    end
    if (entry >= steps.size()) begin
      return "drain";
    end
    return stepNames[entry];
  endfunction

  // model one sampled edge and queue what the outputs show two edges later
  task automatic predict(input stimT s, input int entry);
    expectT   e;
    rowIndexT rdRow;
    rowIndexT wrRow;
    e = '0;
    e.entry = entry;
    // row index is the byte address without its offset inside the row
    rdRow = rowIndexT'(s.rd.addr / (rowBits / 8));
    wrRow = rowIndexT'(s.wr.addr / (rowBits / 8));
    // the read sees the array as it was before this edge's write
    for (int w = 0; w < nWays; w++) begin
      if (s.rd.valid && s.rd.wayEn[w]) begin
        lastResp[w] = refMem[w][rdRow];
        e.valid[w] = 1'b1;
      end
      e.data[w] = lastResp[w];
    end
    // each enabled word of every selected way takes the new data
    for (int w = 0; w < nWays; w++) begin
      for (int k = 0; k < rowWords; k++) begin
        if (s.wr.valid && s.wr.wayEn[w] && s.wr.wordMask[k]) begin
          refMem[w][wrRow][k*wordBits +: wordBits] = s.wr.data[k*wordBits +: wordBits];
        end
      end
    end
    pending.push_back(e);
  endtask

  // compare the oldest prediction with what the DUT shows now
  task automatic checkResponse();
    expectT e;
    string  name;
    e = pending.pop_front();
    name = testName(e.entry);
    assert (respWayValid === e.valid) else begin
      $display("[FAIL] %s respWayValid expected %h actual %h", name, e.valid, respWayValid);
      validErrors++;
    end
    for (int w = 0; w < nWays; w++) begin
      assert (respData[w] === e.data[w]) else begin
        $display("[FAIL] %s way %0d respData expected %h actual %h",
                 name, w, e.data[w], respData[w]);
        dataErrors++;
      end
    end
  endtask

  // the table touches rows 01 ff and 3a in way 2 and row 7a in ways 0 4 5 6 7
  task automatic buildTable();
    addStep("fullWriteWay2",   0, 8'h00, 12'h000, 1, 8'h04, 12'h010, 2'b11);
    addStep("readWay2",        1, 8'h04, 12'h010, 0, 8'h00, 12'h000, 2'b00);
    addStep("idleGap",         0, 8'h00, 12'h000, 0, 8'h00, 12'h000, 2'b00);
    addStep("maskLowWord",     0, 8'h00, 12'h000, 1, 8'h04, 12'h010, 2'b01);
    addStep("maskHighWord",    0, 8'h00, 12'h000, 1, 8'h04, 12'h010, 2'b10);
    addStep("readMasked",      1, 8'h04, 12'h010, 0, 8'h00, 12'h000, 2'b00);
    addStep("multiWayWrite",   0, 8'h00, 12'h000, 1, 8'hf1, 12'h7a0, 2'b11);
    addStep("readWay5",        1, 8'h20, 12'h7a0, 0, 8'h00, 12'h000, 2'b00);
    addStep("readWay0Offset",  1, 8'h01, 12'h7ac, 0, 8'h00, 12'h000, 2'b00);
    addStep("writeRowFf",      0, 8'h00, 12'h000, 1, 8'h04, 12'hff0, 2'b11);
    addStep("writeRow3a",      0, 8'h00, 12'h000, 1, 8'h04, 12'h3a8, 2'b11);
    addStep("backToBackFf",    1, 8'h04, 12'hff8, 0, 8'h00, 12'h000, 2'b00);
    addStep("backToBack3a",    1, 8'h04, 12'h3a4, 0, 8'h00, 12'h000, 2'b00);
    addStep("backToBack01",    1, 8'h04, 12'h01f, 0, 8'h00, 12'h000, 2'b00);
    addStep("readDuringWrite", 1, 8'h04, 12'h3a0, 1, 8'h04, 12'h3a0, 2'b11);
    addStep("readAfterWrite",  1, 8'h04, 12'h3a0, 0, 8'h00, 12'h000, 2'b00);
    addStep("readMultiWay",    1, 8'hf1, 12'h7a0, 0, 8'h00, 12'h000, 2'b00);
    addStep("readWithMaskWr",  1, 8'h80, 12'h7a0, 1, 8'h80, 12'h7a0, 2'b01);
    addStep("readWays0And7",   1, 8'h81, 12'h7a8, 0, 8'h00, 12'h000, 2'b00);
  endtask

  // stops a run that stalls after a time sized from the table length
  initial begin
    wait (tableReady);
    #((steps.size() + 20) * 4 * 2);
    $display("watchdog expired before every table entry was checked");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    stimT   cur;
    expectT idle;
    readReq = '0;
    writeReq = '0;
    seed = 32'h009dedd3;
    validErrors = 0;
    dataErrors = 0;
    for (int w = 0; w < nWays; w++) begin
      lastResp[w] = '0;
    end
    buildTable();
    tableReady = 1'b1;

    // the first two checks see the cleared response registers
    idle = '0;
    idle.entry = -1;
    pending.push_back(idle);
    pending.push_back(idle);

    @(negedge reset);
    @(negedge clock);

    // two extra idle cycles drain the last responses
    for (int c = 0; c < steps.size() + 2; c++) begin
      @(negedge clock);
      checkResponse();
      if (c < steps.size()) begin
        cur = steps[c];
      end else begin
        cur = '0;
      end
      readReq = cur.rd;
      writeReq = cur.wr;
      predict(cur, c);
    end

    $display("table entries %0d, valid errors %0d, data errors %0d",
             steps.size(), validErrors, dataErrors);
    if (validErrors + dataErrors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== dv/clockGen.sv ====
// clock and reset for the data array testbench
// 4 ns clock, reset held high for the first 8 rising edges
`timescale 1ns/1ps

module clockGen (
  output logic clock,
  output logic reset
);

  // free running clock, 2 ns per phase
  initial begin
    clock = 1'b0;
    forever begin
      #2 clock = ~clock;
    end
  end

  // release reset on a falling edge so the first sampled edge is clean
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

// ==== verilog/dataArray.sv ====
// data array of the non-blocking L1 data cache
// one dataBank per way feeds a shared response register stage
// a read is answered two register stages later, a write is seen by the next read
`timescale 1ns/1ps

module dataArray
  import cacheGeometryPkg::*;
  import cacheRequestPkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  dataReadReqT  readReq,
  input  dataWriteReqT writeReq,
  output rowT          respData [nWays],
  output wayMaskT      respWayValid
);

  // rows read out of each way on the last edge
  rowT bankData [nWays];

  // one bit per way that performed a read on the last edge
  wayMaskT bankHit;

  // first stage, one storage bank per way
  // all banks see the same request buses and decode their own way bit
  for (genvar w = 0; w < nWays; w++) begin : gWay
    dataBank #(
      .wayIndex(w)
    ) dataBank_i (
      .clock   (clock),
      .reset   (reset),
      .readReq (readReq),
      .writeReq(writeReq),
      .bankData(bankData[w]),
      .bankHit (bankHit[w])
    );
  end

  // second stage, per-way response registers and valid flags
  responseStage responseStage_i (
    .clock       (clock),
    .reset       (reset),
    .bankData    (bankData),
    .bankHit     (bankHit),
    .respData    (respData),
    .respWayValid(respWayValid)
  );

  // end to end, a way answers exactly two edges after it was read
  assert property (@(posedge clock) disable iff (reset)
    (readReq.valid && readReq.wayEn != '0) |-> ##2 ((respWayValid & $past(readReq.wayEn, 2))
      == $past(readReq.wayEn, 2)))
    else $error("read response missing two edges after request");

endmodule

// ==== verilog/responseStage.sv ====
// second pipeline stage that holds the last row read from each way
// respWayValid flags the ways whose respData was loaded on the last edge
`timescale 1ns/1ps

module responseStage
  import cacheGeometryPkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  rowT     bankData [nWays],
  input  wayMaskT bankHit,
  output rowT     respData [nWays],
  output wayMaskT respWayValid
);

  // per-way response registers
  // a way that was not read keeps what it loaded last
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int w = 0; w < nWays; w++) begin
        respData[w] <= '0;
      end
    end else begin
      for (int w = 0; w < nWays; w++) begin
        if (bankHit[w]) begin
          respData[w] <= bankData[w];
        end
      end
    end
  end

  // valid follows the bank hits one edge later
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      respWayValid <= '0;
    end else begin
      respWayValid <= bankHit;
    end
  end

  // a way without a read on the previous edge must hold its response
  for (genvar w = 0; w < nWays; w++) begin : gHoldCheck
    assert property (@(posedge clock) disable iff (reset)
      (!$past(bankHit[w]) && !$past(reset)) |-> $stable(respData[w]))
      else $error("respData of way %0d changed without a read", w);
  end

endmodule

// ==== verilog/dataBank.sv ====
// storage of one cache way, two word-wide banks sharing one row index
// masked write and synchronous read, data comes out one cycle after the request edge
`timescale 1ns/1ps

module dataBank
  import cacheGeometryPkg::*;
  import cacheRequestPkg::*;
#(
  // the way this bank serves, picks its bit out of wayEn
  parameter int wayIndex = 0
) (
  input  logic         clock,
  input  logic         reset,
  input  dataReadReqT  readReq,
  input  dataWriteReqT writeReq,
  output rowT          bankData,
  output logic         bankHit
);

  // per-way enables decoded from the shared request buses
  logic readEn;
  logic writeEn;

  // row indices with the byte offset stripped
  rowIndexT readRow;
  rowIndexT writeRow;

  // one memory per word of the row
  wordT wordMem [rowWords][nRows];

  // this way takes part only when its wayEn bit is set
  assign readEn = readReq.valid && readReq.wayEn[wayIndex];
  assign writeEn = writeReq.valid && writeReq.wayEn[wayIndex];

  // drop the offset inside the row
  assign readRow = readReq.addr[addrBits-1:rowOffBits];
  assign writeRow = writeReq.addr[addrBits-1:rowOffBits];

  // write and read share one process per edge
  // nonblocking update means a read of the row being written sees old data
  always_ff @(posedge clock) begin
    for (int w = 0; w < rowWords; w++) begin
      // each word only where the mask allows
      if (writeEn && writeReq.wordMask[w]) begin
        wordMem[w][writeRow] <= writeReq.data[w*wordBits +: wordBits];
      end
      // both words are read together into the row
      if (readEn) begin
        bankData[w*wordBits +: wordBits] <= wordMem[w][readRow];
      end
    end
  end

  // marks that bankData was loaded on the last edge
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bankHit <= 1'b0;
    end else begin
      bankHit <= readEn;
    end
  end

  // the response stage keys its load off bankHit so it must never be X
  assert property (@(posedge clock) disable iff (reset)
    !$isunknown(bankHit))
    else $error("bankHit unknown in way %0d", wayIndex);

  // a write into this way needs a known row or it would corrupt the array
  assert property (@(posedge clock) disable iff (reset)
    writeEn |-> !$isunknown(writeRow))
    else $error("write to way %0d with unknown row", wayIndex);

  // a read reported by bankHit carries a known row index one edge earlier
  assert property (@(posedge clock) disable iff (reset)
    bankHit |-> !$isunknown($past(readRow)))
    else $error("read of way %0d from unknown row", wayIndex);

endmodule

// ==== verilog/cacheRequestPkg.sv ====
// request structs seen at the data array ports
// a request is taken on any rising clock edge with valid high, there is no ready
package cacheRequestPkg;

  import cacheGeometryPkg::*;

  // read of one row from any set of ways
  typedef struct packed {
    // request is live this cycle
    logic valid;
    // ways to read, each selected way answers on its own
    wayMaskT wayEn;
    // byte address, the low row offset bits are ignored
    addrT addr;
  } dataReadReqT;

  // masked write of one row into any set of ways
  typedef struct packed {
    // request is live this cycle
    logic valid;
    // ways to write, all selected ways take the same data
    wayMaskT wayEn;
    // byte address, the low row offset bits are ignored
    addrT addr;
    // which words of the row get written
    wordMaskT wordMask;
    // row payload, word 0 in the low half
    rowT data;
  } dataWriteReqT;

  // widths are fixed by the cache geometry
  localparam int readReqBits = $bits(dataReadReqT);
  localparam int writeReqBits = $bits(dataWriteReqT);

endpackage

// ==== verilog/cacheGeometryPkg.sv ====
// geometry of the L1 data array and the vector types built from it
// imported by the request package and by every RTL module of the array
package cacheGeometryPkg;

  // associativity and set count of the cache
  localparam int nWays = 8;
  localparam int nSets = 64;

  // a refill brings a line in over this many beats, one row per beat
  localparam int refillCycles = 4;

  // a row is the unit read or written in one access
  localparam int rowWords = 2;
  localparam int wordBits = 64;
  localparam int rowBits = rowWords * wordBits;

  // byte offset inside a row, dropped when forming the row index
  localparam int rowOffBits = $clog2(rowBits / 8);

  // rows held by each way, one per set and refill beat
  localparam int nRows = nSets * refillCycles;
  localparam int rowIndexBits = $clog2(nRows);

  // byte address covers the row index plus the row offset
  localparam int addrBits = rowIndexBits + rowOffBits;

  // byte address of a request
  typedef logic [addrBits-1:0] addrT;

  // row number inside one way
  typedef logic [rowIndexBits-1:0] rowIndexT;

  // one data word
  typedef logic [wordBits-1:0] wordT;

  // a full row, word 0 sits in the low half
  typedef logic [rowBits-1:0] rowT;

  // one bit per way, any number of ways may be set
  typedef logic [nWays-1:0] wayMaskT;

  // write enable per word of a row
  typedef logic [rowWords-1:0] wordMaskT;

endpackage
